//--- bench/clock_gen.sv
/*
  Clock and reset source for the testbench.
  clk_sys has a 4 ns period.
  reset is high from time 0 and drops on the third rising edge.
*/
`timescale 1ns/10ps

module clock_gen
(
    output logic clk_sys,
    output logic reset
);

    initial
    begin
        clk_sys = 1'b0;
        forever
            #2 clk_sys = ~clk_sys;
    end

    // reset released with a non-blocking update on the clock edge
    initial
    begin
        reset = 1'b1;
        repeat (3)
            @(posedge clk_sys);
        reset <= 1'b0;
    end

endmodule

//--- bench/lcd_video_check.sv
/*
  Checker for the LCD video path.
  Samples the DUT on falling edges where ce_pix is high, when video is stable.
  Raster position is anchored on the first vs rise and checked from then on.
  A frame check runs from one vs rise to the next.
  The bank copy is filled by the testbench after each capture.
*/
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_video_check
(
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                frame_done,
    input  logic [5:0]          lcd_contrast,
    input  lcd_pkg::lcd_pos_t   lcd_req,
    input  logic                ce_pix,
    input  lcd_pkg::video_out_t video,
    input  logic                check_req,
    input  int                  test_id,
    input  logic                grey_check,
    output logic                check_done,
    output int                  errors,
    output int                  tests_done
);

    // last four captured frames, one slot per bank
    logic [7:0] frames [`FB_BANKS][`FB_DEPTH];
    int         slot;

    // raster tracking
    logic       anchored;
    logic       prev_vs;
    int         hcount;
    int         vline;

    // frame check state
    logic       busy;
    int         active_cnt;
    int         frame_errs;

    // reset state test
    logic       after_reset;
    logic       watch_req;
    int         reset_errs;

    initial
    begin
        slot        = 0;
        anchored    = 1'b0;
        prev_vs     = 1'b0;
        hcount      = 0;
        vline       = 0;
        busy        = 1'b0;
        active_cnt  = 0;
        frame_errs  = 0;
        after_reset = 1'b0;
        watch_req   = 1'b0;
        reset_errs  = 0;
        check_done  = 1'b0;
        errors      = 0;
        tests_done  = 0;
    end

    task automatic store_byte(input int addr, input logic [7:0] data);
        frames[slot][addr] = data;
    endtask

    task automatic next_slot();
        slot = (slot + 1) % `FB_BANKS;
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    // printable name of a capture state
    function automatic string state_name(input lcd_pkg::capture_state_t s);
        return s.name();
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // grey of lcd pixel x, y over the four stored frames
    function automatic logic [7:0] expected_grey(input int x, input int y,
                                                 input logic [5:0] contrast);
        int         bright;
        int         lit;
        logic [7:0] col;
        if (contrast >= `CONTRAST_SAT)
            bright = 255;
        else
            bright = int'(contrast[4:0]) * 8;
        lit = 0;
        for (int b = 0; b < `FB_BANKS; b++)
        begin
            col = frames[b][(y / 8) * `LCD_XSIZE + x];
            // a cleared bit is a dark lcd dot
            if (col[y % 8] == 1'b0)
                lit++;
        end
        return 8'((bright * lit) / 4);
    endfunction

    ////////////////////////////////////////////////////////////
    // per pixel compare
    ////////////////////////////////////////////////////////////

    task automatic check_pixel();
        lcd_pkg::video_sync_t s;
        lcd_pkg::video_sync_t exp;
        logic                 vs_rise;
        logic [7:0]           exp_grey;
        s       = video.sync;
        vs_rise = s.vs && !prev_vs;
        prev_vs = s.vs;
        if (vs_rise)
        begin
            if (busy)
            begin
                if (active_cnt != `LCD_XSIZE * `LCD_YSIZE)
                begin
                    report_fail($sformatf("frame had %0d active pixels, expected %0d",
                                          active_cnt, `LCD_XSIZE * `LCD_YSIZE));
                    frame_errs++;
                end
                $display("test %0d: %0d active pixels, %0d errors",
                         test_id, active_cnt, frame_errs);
                tests_done++;
                busy       = 1'b0;
                check_done = 1'b1;
            end
            else if (check_req && !check_done)
            begin
                busy       = 1'b1;
                active_cnt = 0;
                frame_errs = 0;
            end
            // vs rises on pixel 0 of the first sync line
            anchored = 1'b1;
            hcount   = 0;
            vline    = `VS_START;
        end
        else if (anchored)
        begin
            hcount++;
            if (hcount == `H_WIDTH)
            begin
                hcount = 0;
                vline  = (vline + 1) % `V_HEIGHT;
            end
        end

        if (anchored)
        begin
            exp.hs     = (hcount >= `HS_START) && (hcount < `HS_START + `HS_WIDTH);
            exp.vs     = (vline >= `VS_START) && (vline < `VS_END);
            exp.hblank = !((hcount >= `H_ACTIVE_START) &&
                           (hcount < `H_ACTIVE_START + `LCD_XSIZE));
            exp.vblank = !((vline >= `V_ACTIVE_START) &&
                           (vline < `V_ACTIVE_START + `LCD_YSIZE));
            if (s !== exp)
            begin
                report_fail($sformatf("sync %b, expected %b at pixel %0d line %0d",
                                      s, exp, hcount, vline));
                if (busy)
                    frame_errs++;
            end
        end

        // lcd coordinate counted from the blanking outputs
        if (busy && !s.hblank && !s.vblank)
        begin
            if (grey_check && active_cnt < `LCD_XSIZE * `LCD_YSIZE)
            begin
                exp_grey = expected_grey(active_cnt % `LCD_XSIZE,
                                         active_cnt / `LCD_XSIZE, lcd_contrast);
                if (video.grey !== exp_grey)
                begin
                    report_fail($sformatf("grey %0d, expected %0d at lcd x %0d y %0d",
                                          video.grey, exp_grey,
                                          active_cnt % `LCD_XSIZE,
                                          active_cnt / `LCD_XSIZE));
                    frame_errs++;
                end
            end
            active_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////

    always @(negedge clk_sys)
    begin
        if (reset)
        begin
            after_reset = 1'b1;
            watch_req   = 1'b1;
            anchored    = 1'b0;
            prev_vs     = 1'b0;
        end
        else
        begin
            // first clock out of reset
            if (after_reset)
            begin
                if (video.grey !== 8'd0 || video.sync.hs !== 1'b0 || video.sync.vs !== 1'b0)
                begin
                    report_fail("hs, vs or grey not 0 after reset");
                    reset_errs++;
                end
                after_reset = 1'b0;
            end
            // lcd_req holds at 0 until the first frame_done
            if (watch_req)
            begin
                if (frame_done)
                begin
                    $display("test 1: reset state, %0d errors", reset_errs);
                    tests_done++;
                    watch_req = 1'b0;
                end
                else if (lcd_req !== '0)
                begin
                    report_fail($sformatf("lcd_req at x %0d row %0d while capture is %s",
                                          lcd_req.x, lcd_req.row,
                                          state_name(lcd_pkg::capture_idle)));
                    reset_errs++;
                end
            end
            if (ce_pix)
                check_pixel();
            if (!check_req)
                check_done = 1'b0;
        end
    end

endmodule

//--- bench/lcd_video_tb.sv
/*
  Testbench top for the LCD video path.
  The LCD model answers lcd_req in the same cycle from a table of random
  frames. Frame numbers outside the table answer X.
  Tests run in order and each frame check waits on the checker.
  A watchdog stops the run after 12 raster frames.
*/
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_video_tb;

    // one raster frame in clk_sys cycles, ce_pix is one clock in four
    localparam int FRAME_CLOCKS = `H_WIDTH * `V_HEIGHT * 4;
    localparam int NUM_FRAMES   = 6;

    logic                clk_sys;
    logic                reset;
    logic                frame_done;
    logic [5:0]          lcd_contrast;
    lcd_pkg::lcd_pos_t   lcd_req;
    logic [7:0]          lcd_column;
    logic                ce_pix;
    lcd_pkg::video_out_t video;

    // checker control
    logic                check_req;
    int                  test_id;
    logic                grey_check;
    logic                check_done;
    int                  errors;
    int                  tests_done;

    // lcd model state
    int                  lcd_frame;
    integer              seed;
    logic [7:0]          pattern [NUM_FRAMES][`FB_DEPTH];

    clock_gen u_clock
    (
        .clk_sys (clk_sys),
        .reset   (reset)
    );

    lcd_video_top u_dut
    (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .frame_done   (frame_done),
        .lcd_contrast (lcd_contrast),
        .lcd_req      (lcd_req),
        .lcd_column   (lcd_column),
        .ce_pix       (ce_pix),
        .video        (video)
    );

    lcd_video_check u_check
    (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .frame_done   (frame_done),
        .lcd_contrast (lcd_contrast),
        .lcd_req      (lcd_req),
        .ce_pix       (ce_pix),
        .video        (video),
        .check_req    (check_req),
        .test_id      (test_id),
        .grey_check   (grey_check),
        .check_done   (check_done),
        .errors       (errors),
        .tests_done   (tests_done)
    );

    ////////////////////////////////////////////////////////////
    // lcd model
    ////////////////////////////////////////////////////////////

    // column byte at x, row of the given frame
    function automatic logic [7:0] lcd_byte(input int frame, input lcd_pkg::lcd_pos_t p);
        return pattern[frame][int'(p.row) * `LCD_XSIZE + int'(p.x)];
    endfunction

    assign lcd_column = lcd_byte(lcd_frame, lcd_req);

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic pulse_frame_done();
        @(posedge clk_sys);
        frame_done <= 1'b1;
        @(posedge clk_sys);
        frame_done <= 1'b0;
    endtask

    // a copy has ended once the last byte was requested and lcd_req is back at 0
    task automatic wait_copy_end();
        while (!(lcd_req.x == 7'(`LCD_XSIZE - 1) && lcd_req.row == 3'(`LCD_COLS - 1)))
            @(negedge clk_sys);
        while (lcd_req !== '0)
            @(negedge clk_sys);
    endtask

    // hand the captured frame to the checker's bank copy
    task automatic record_frame(input int frame);
        for (int a = 0; a < `FB_DEPTH; a++)
            u_check.store_byte(a, pattern[frame][a]);
        u_check.next_slot();
    endtask

    task automatic capture_frame(input int frame, input logic second_pulse);
        @(posedge clk_sys);
        lcd_frame <= frame;
        pulse_frame_done();
        if (second_pulse)
        begin
            // hit the copy in the middle, this pulse must be dropped
            while (lcd_req.row != 3'd3)
                @(negedge clk_sys);
            pulse_frame_done();
        end
        wait_copy_end();
        record_frame(frame);
    endtask

    // one full raster frame checked by u_check
    task automatic frame_check(input int id, input logic with_grey);
        @(posedge clk_sys);
        test_id    <= id;
        grey_check <= with_grey;
        check_req  <= 1'b1;
        wait (check_done);
        @(posedge clk_sys);
        check_req <= 1'b0;
        wait (!check_done);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        seed = 12871;
        for (int f = 0; f < NUM_FRAMES; f++)
            for (int a = 0; a < `FB_DEPTH; a++)
                pattern[f][a] = 8'($random(seed));
        frame_done   = 1'b0;
        lcd_contrast = 6'h13;
        // no frame selected yet
        lcd_frame    = -1;
        check_req    = 1'b0;
        test_id      = 0;
        grey_check   = 1'b0;

        wait (reset === 1'b0);
        // raster only, the banks are still empty
        frame_check(2, 1'b0);

        for (int f = 0; f < 4; f++)
            capture_frame(f, 1'b0);
        @(posedge video.sync.vs);
        frame_check(3, 1'b1);

        // saturated contrast
        @(posedge clk_sys);
        lcd_contrast <= 6'h2a;
        frame_check(4, 1'b1);

        // double frame_done during one copy
        @(posedge clk_sys);
        lcd_contrast <= 6'h1f;
        capture_frame(4, 1'b1);
        @(posedge video.sync.vs);
        frame_check(5, 1'b1);

        $display("tests reported %0d of 5, errors %0d", tests_done, errors);
        if (errors == 0 && tests_done == 5)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog sized for the whole sequence with margin
    initial
    begin
        repeat (12 * FRAME_CLOCKS)
            @(posedge clk_sys);
        $display("watchdog expired after 12 raster frames, the test sequence did not end");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/lcd_pkg.sv
source/frame_capture.sv
source/frame_store.sv
source/lcd_timing.sv
source/pixel_blend.sv
source/lcd_video_top.sv
bench/clock_gen.sv
bench/lcd_video_check.sv
bench/lcd_video_tb.sv

//--- source/frame_capture.sv
/*
  Copies one LCD frame into the current frame bank after each frame_done.
  The LCD source must answer lcd_req on lcd_column in the same cycle.
  One byte is written every other clock, 768 writes per frame.
  A frame_done that arrives while a copy runs is dropped, not queued.
*/
`timescale 1ns/10ps
`include "lcd_settings.svh"

module frame_capture
(
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              frame_done,
    input  logic [7:0]        lcd_column,
    output lcd_pkg::lcd_pos_t lcd_req,
    output logic              wr_en,
    output lcd_pkg::lcd_pos_t wr_pos,
    output logic [7:0]        wr_data,
    output logic [1:0]        wr_bank
);

    lcd_pkg::capture_state_t state;
    lcd_pkg::lcd_pos_t       pos;
    // half rate pacing toggle
    logic                    phase;
    logic [1:0]              bank;
    logic                    last_x;
    logic                    last_byte;

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    assign last_x    = (pos.x == 7'(`LCD_XSIZE - 1));
    assign last_byte = last_x && (pos.row == 3'(`LCD_COLS - 1));

    // the lcd answers combinationally so the byte goes straight to the store
    assign lcd_req = pos;
    assign wr_pos  = pos;
    assign wr_data = lcd_column;
    assign wr_bank = bank;
    assign wr_en   = (state == lcd_pkg::capture_copy) && phase;

    ////////////////////////////////////////////////////////////
    // copy sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            state <= lcd_pkg::capture_idle;
            pos   <= '0;
            phase <= 1'b0;
            bank  <= '0;
        end
        else
        begin
            phase <= ~phase;
            case (state)
                lcd_pkg::capture_idle:
                begin
                    // latch the frame complete pulse
                    if (frame_done)
                        state <= lcd_pkg::capture_copy;
                end
                lcd_pkg::capture_copy:
                begin
                    // step on the write cycle only
                    if (phase)
                    begin
                        if (last_byte)
                        begin
                            pos   <= '0;
                            // banks rotate modulo four
                            bank  <= bank + 2'd1;
                            state <= lcd_pkg::capture_idle;
                        end
                        else if (last_x)
                        begin
                            pos.x   <= '0;
                            pos.row <= pos.row + 3'd1;
                        end
                        else
                            pos.x <= pos.x + 7'd1;
                    end
                end
                default:
                    state <= lcd_pkg::capture_idle;
            endcase
        end
    end

endmodule

//--- source/frame_store.sv
/*
  Four frame banks of 768 bytes each.
  One write port into the bank chosen by wr_bank.
  The read port reads the same address from every bank and returns
  all four bytes one clock after rd_pos.
  Reading and writing the same byte in one clock returns the old byte.
*/
`timescale 1ns/10ps
`include "lcd_settings.svh"

module frame_store
(
    input  logic                         clk_sys,
    input  logic                         wr_en,
    input  logic [1:0]                   wr_bank,
    input  lcd_pkg::lcd_pos_t            wr_pos,
    input  logic [7:0]                   wr_data,
    input  lcd_pkg::lcd_pos_t            rd_pos,
    output logic [`FB_BANKS-1:0][7:0]    rd_data
);

    logic [9:0] wr_addr;
    logic [9:0] rd_addr;

    // linear byte address, row times lcd width plus x
    function automatic logic [9:0] byte_addr(input lcd_pkg::lcd_pos_t p);
        return 10'(p.row) * 10'(`LCD_XSIZE) + 10'(p.x);
    endfunction

    assign wr_addr = byte_addr(wr_pos);
    assign rd_addr = byte_addr(rd_pos);

    ////////////////////////////////////////////////////////////
    // one ram per bank
    ////////////////////////////////////////////////////////////

    for (genvar b = 0; b < `FB_BANKS; b++)
    begin : g_bank
        logic [7:0] mem [`FB_DEPTH];

        always_ff @(posedge clk_sys)
        begin
            if (wr_en && (wr_bank == 2'(b)))
                mem[wr_addr] <= wr_data;
            // read every clock, the blender picks the bit later
            rd_data[b] <= mem[rd_addr];
        end
    end

endmodule

//--- source/lcd_pkg.sv
/*
  Shared types for the LCD capture and video path.
  Field widths are fixed for the 96 by 64 panel and four frame banks.
*/
package lcd_pkg;

    ////////////////////////////////////////////////////////////
    // capture engine state
    ////////////////////////////////////////////////////////////

    typedef enum logic [0:0]
    {
        capture_idle = 1'b0,
        capture_copy = 1'b1
    } capture_state_t;

    ////////////////////////////////////////////////////////////
    // positions and video signals
    ////////////////////////////////////////////////////////////

    // position of one column byte on the lcd
    typedef struct packed
    {
        // pixel column, 0 to 95
        logic [6:0] x;
        // column byte row, each row covers 8 pixel lines
        logic [2:0] row;
    } lcd_pos_t;

    // raster sync and blanking, all active high
    typedef struct packed
    {
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
    } video_sync_t;

    // registered output pixel with its sync
    typedef struct packed
    {
        logic [7:0]  grey;
        video_sync_t sync;
    } video_out_t;

endpackage

//--- source/lcd_settings.svh
/*
  Geometry of the LCD, the frame banks and the output raster.
  The LCD is read as 8-pixel column bytes, LCD_COLS rows of LCD_XSIZE bytes.
  FB_DEPTH must equal LCD_XSIZE * LCD_COLS.
  The raster is clocked by a pixel enable at a quarter of clk_sys.
*/
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// lcd panel and frame banks
`define LCD_XSIZE       96
`define LCD_YSIZE       64
`define LCD_COLS        8
`define FB_DEPTH        768
`define FB_BANKS        4

// output raster, counted in pixel enables and lines
`define H_WIDTH         140
`define V_HEIGHT        119
`define H_ACTIVE_START  16
`define V_ACTIVE_START  32
`define HS_START        120
`define HS_WIDTH        16
`define VS_START        1
`define VS_END          4

// contrast register value where the lit level tops out at full white
`define CONTRAST_SAT    6'h20

`endif

//--- source/lcd_timing.sv
/*
  Raster timing for a 140 by 119 frame with the 96 by 64 LCD image
  starting at pixel 16 of line 32.
  All raster state moves on ce_pix, one clock in four.
  Sync, blanking, rd_pos and bit_sel are registered on the same ce_pix
  and describe the same pixel.
*/
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_timing
(
    input  logic                 clk_sys,
    input  logic                 reset,
    output logic                 ce_pix,
    output lcd_pkg::lcd_pos_t    rd_pos,
    output logic [2:0]           bit_sel,
    output lcd_pkg::video_sync_t sync
);

    logic [1:0] div;
    logic [7:0] hpos;
    logic [6:0] vpos;
    // lcd pixel coordinate of the next active pixel
    logic [6:0] x;
    logic [5:0] y;
    logic       h_active;
    logic       v_active;

    // pixel enable on the last clock of four
    assign ce_pix = (div == 2'b11);

    assign h_active = (hpos >= 8'(`H_ACTIVE_START)) &&
                      (hpos < 8'(`H_ACTIVE_START + `LCD_XSIZE));
    assign v_active = (vpos >= 7'(`V_ACTIVE_START)) &&
                      (vpos < 7'(`V_ACTIVE_START + `LCD_YSIZE));

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            div     <= '0;
            hpos    <= '0;
            vpos    <= '0;
            x       <= '0;
            y       <= '0;
            rd_pos  <= '0;
            bit_sel <= '0;
            sync    <= '{hs: 1'b0, vs: 1'b0, hblank: 1'b1, vblank: 1'b1};
        end
        else
        begin
            div <= div + 2'd1;
            if (ce_pix)
            begin
                ////////////////////////////////////////////////////////////
                // raster counters
                ////////////////////////////////////////////////////////////
                if (hpos == 8'(`H_WIDTH - 1))
                begin
                    hpos <= '0;
                    if (vpos == 7'(`V_HEIGHT - 1))
                        vpos <= '0;
                    else
                        vpos <= vpos + 7'd1;
                end
                else
                    hpos <= hpos + 8'd1;

                // sync and blanking for the pixel at hpos, vpos
                sync.hs     <= (hpos >= 8'(`HS_START)) &&
                               (hpos < 8'(`HS_START + `HS_WIDTH));
                sync.vs     <= (vpos >= 7'(`VS_START)) && (vpos < 7'(`VS_END));
                sync.hblank <= ~h_active;
                sync.vblank <= ~v_active;

                // store address for the same pixel
                rd_pos.x   <= x;
                rd_pos.row <= y[5:3];
                bit_sel    <= y[2:0];

                ////////////////////////////////////////////////////////////
                // lcd coordinate
                ////////////////////////////////////////////////////////////
                if (!v_active)
                begin
                    x <= '0;
                    y <= '0;
                end
                else if (h_active)
                begin
                    if (x == 7'(`LCD_XSIZE - 1))
                    begin
                        x <= '0;
                        y <= y + 6'd1;
                    end
                    else
                        x <= x + 7'd1;
                end
            end
        end
    end

endmodule

//--- source/lcd_video_top.sv
/*
  LCD output path: frame capture, four-bank store, raster timing and blend.
  The LCD source answers lcd_req on lcd_column in the same cycle.
  video changes two clocks after the ce_pix that selected the pixel.
*/
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_video_top
(
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                frame_done,
    input  logic [5:0]          lcd_contrast,
    output lcd_pkg::lcd_pos_t   lcd_req,
    input  logic [7:0]          lcd_column,
    output logic                ce_pix,
    output lcd_pkg::video_out_t video
);

    // capture to store
    logic                      wr_en;
    lcd_pkg::lcd_pos_t         wr_pos;
    logic [7:0]                wr_data;
    logic [1:0]                wr_bank;

    // timing to store and blend
    lcd_pkg::lcd_pos_t         rd_pos;
    logic [2:0]                bit_sel;
    lcd_pkg::video_sync_t      sync;
    logic [`FB_BANKS-1:0][7:0] rd_data;

    ////////////////////////////////////////////////////////////
    // capture side
    ////////////////////////////////////////////////////////////

    frame_capture u_capture
    (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .frame_done (frame_done),
        .lcd_column (lcd_column),
        .lcd_req    (lcd_req),
        .wr_en      (wr_en),
        .wr_pos     (wr_pos),
        .wr_data    (wr_data),
        .wr_bank    (wr_bank)
    );

    frame_store u_store
    (
        .clk_sys (clk_sys),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_pos  (wr_pos),
        .wr_data (wr_data),
        .rd_pos  (rd_pos),
        .rd_data (rd_data)
    );

    ////////////////////////////////////////////////////////////
    // video side
    ////////////////////////////////////////////////////////////

    lcd_timing u_timing
    (
        .clk_sys (clk_sys),
        .reset   (reset),
        .ce_pix  (ce_pix),
        .rd_pos  (rd_pos),
        .bit_sel (bit_sel),
        .sync    (sync)
    );

    pixel_blend u_blend
    (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .lcd_contrast (lcd_contrast),
        .rd_data      (rd_data),
        .bit_sel      (bit_sel),
        .sync         (sync),
        .video        (video)
    );

endmodule

//--- source/pixel_blend.sv
/*
  Blends the same pixel from the four banks into one grey level.
  A pixel is lit in a bank where its bit is 0.
  grey = brightness * lit banks / 4, brightness set by the lcd contrast.
  rd_data must arrive one clock after the timing registers change.
*/
`timescale 1ns/10ps
`include "lcd_settings.svh"

module pixel_blend
(
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic [5:0]                lcd_contrast,
    input  logic [`FB_BANKS-1:0][7:0] rd_data,
    input  logic [2:0]                bit_sel,
    input  lcd_pkg::video_sync_t      sync,
    output lcd_pkg::video_out_t       video
);

    logic [7:0]           brightness;
    logic [2:0]           lit_count;
    logic [9:0]           grey_sum;
    // sync held back one clock to line up with the ram data
    lcd_pkg::video_sync_t sync_d;

    // saturates at full white, otherwise 8 steps per contrast unit
    assign brightness = (lcd_contrast >= `CONTRAST_SAT) ? 8'd255 :
                        {lcd_contrast[4:0], 3'd0};

    always_comb
    begin
        lit_count = '0;
        for (int b = 0; b < `FB_BANKS; b++)
            lit_count = lit_count + 3'(!rd_data[b][bit_sel]);
    end

    assign grey_sum = 10'(brightness) * 10'(lit_count);

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            sync_d <= '{hs: 1'b0, vs: 1'b0, hblank: 1'b1, vblank: 1'b1};
            video  <= '{grey: 8'd0, sync: '{hs: 1'b0, vs: 1'b0, hblank: 1'b1, vblank: 1'b1}};
        end
        else
        begin
            sync_d     <= sync;
            // average over the four banks
            video.grey <= grey_sum[9:2];
            video.sync <= sync_d;
        end
    end

endmodule
